// ==== src.f ====
pmd_input_pkg.sv
mouse_packet_decoder.sv
quadrature_axis.sv
mouse_port_register.sv
joystick_mapper.sv
pmd_input_top.sv
tb_pmd_input.sv

// ==== tb_pmd_input.sv ====
`timescale 1ns/10ps

module tb_pmd_input import pmd_input_pkg::*; ();

    localparam int unsigned RATE_DIV   = 4;
    localparam int unsigned IDLE_LIMIT = 3000;
    localparam int CLK_HALF   = 10;                 // 20 ns period
    localparam int JOY_ITERS  = 24;
    localparam int STEP_LIMIT = 40;                 // Cycles allowed per quad change
    localparam int WINDOW     = 1024;               // Rate measuring window

    // Test lengths in cycles, summed for the watchdog
    localparam int RESET_CYC = 10 + 10;
    localparam int JOY_CYC   = JOY_ITERS * 3;
    localparam int DIR_CYC   = 4 * (8 + 4 * STEP_LIMIT);
    localparam int RATE_CYC  = 4 * (12 + WINDOW);
    localparam int IDLE_CYC  = IDLE_LIMIT + 100 + 200 + STEP_LIMIT + 2 * 30;
    localparam int TOTAL_CYC = RESET_CYC + JOY_CYC + DIR_CYC + RATE_CYC + IDLE_CYC;
    localparam int WATCHDOG_CYC = TOTAL_CYC + TOTAL_CYC / 5;   // 20% margin

    logic          osc;
    logic          reset;
    mouse_packet_t ps2_mouse;
    logic          mouse_enabled;
    logic          k2_read;
    logic [15:0]   joy0;
    logic [15:0]   joy1;
    joy_port_e     joy_port;
    logic          k3_select;
    logic          k4_select;
    port_byte_t    k2_port;
    port_byte_t    k3_port;
    port_byte_t    k4_port;

    int errors = 0;
    int checks = 0;

    pmd_input_top #(
        .RATE_DIV   (RATE_DIV),
        .IDLE_LIMIT (IDLE_LIMIT)
    ) u_dut (
        .osc           (osc),
        .reset         (reset),
        .ps2_mouse     (ps2_mouse),
        .mouse_enabled (mouse_enabled),
        .k2_read       (k2_read),
        .joy0          (joy0),
        .joy1          (joy1),
        .joy_port      (joy_port),
        .k3_select     (k3_select),
        .k4_select     (k4_select),
        .k2_port       (k2_port),
        .k3_port       (k3_port),
        .k4_port       (k4_port)
    );

    initial begin
        osc = 1'b0;
        forever #CLK_HALF osc = ~osc;
    end

    // ------------------------------------------------------------------------
    // Model helpers, built from the port and motion rules
    // ------------------------------------------------------------------------
    function automatic port_byte_t port_val(input logic drive, input logic [7:0] data);
        port_byte_t p;
        p.drive = drive;
        p.data  = data;
        return p;
    endfunction

    // Active-low joystick byte from both controllers ORed
    function automatic logic [7:0] joy_expected(input logic [15:0] a, input logic [15:0] b);
        logic [15:0] j;
        j = a | b;
        return {3'b111, (j[7:4] == 4'b0000), ~j[1], ~j[0], ~j[3], ~j[2]};
    endfunction

    // Quad pair of one axis as seen on K2
    function automatic quad_t quad_of(input port_byte_t p, input axis_id_e ax);
        quad_t q;
        if (ax == AXIS_X) begin
            q.a = p.data[2];
            q.b = p.data[3];
        end else begin
            q.a = p.data[1];                        // Y pair is swapped
            q.b = p.data[0];
        end
        return q;
    endfunction

    // Next (a,b) in the 00 10 11 01 walk, backwards for sign 1
    function automatic quad_t next_in_sequence(input quad_t cur, input logic sign);
        quad_t seq [4];
        int    idx;
        seq[0] = 2'b00;
        seq[1] = 2'b10;
        seq[2] = 2'b11;
        seq[3] = 2'b01;
        idx = 0;
        for (int i = 0; i < 4; i++) begin
            if (seq[i] == cur) idx = i;
        end
        return sign ? seq[(idx + 3) % 4] : seq[(idx + 1) % 4];
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_port(input port_byte_t got, input port_byte_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got drive %b data %02h, expected drive %b data %02h",
                     $time, what, got.drive, got.data, exp.drive, exp.data);
        end
    endtask

    task automatic check_quad(input quad_t got, input quad_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got ab %b%b, expected ab %b%b",
                     $time, what, got.a, got.b, exp.a, exp.b);
        end
    endtask

    task automatic check_count(input int got, input int exp, input int tol, input string what);
        checks++;
        if (got < exp - tol || got > exp + tol) begin
            errors++;
            $display("Fail at %0t: %s counted %0d steps, expected %0d +/- %0d",
                     $time, what, got, exp, tol);
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus and observation
    // ------------------------------------------------------------------------
    task automatic send_packet(input logic [7:0] xm, input logic xs, input logic [7:0] ym,
                               input logic ys, input logic rb, input logic lb);
        mouse_packet_t pkt;
        pkt           = '0;
        pkt.event_tgl = ~ps2_mouse.event_tgl;      // Flip marks a new packet
        pkt.x_mag     = xm;
        pkt.x_sign    = xs;
        pkt.y_mag     = ym;
        pkt.y_sign    = ys;
        pkt.right     = rb;
        pkt.left      = lb;
        @(posedge osc);
        ps2_mouse <= pkt;
    endtask

    task automatic wait_quad_change(input axis_id_e ax, input quad_t prev, output quad_t now);
        int n;
        n   = 0;
        now = prev;
        while (now == prev && n < STEP_LIMIT) begin
            @(negedge osc);
            now = quad_of(k2_port, ax);
            n++;
        end
        if (now == prev) begin
            errors++;
            $display("Quadrature bits of axis %s did not change within %0d cycles at %0t",
                     ax.name(), STEP_LIMIT, $time);
        end
    endtask

    task automatic count_steps(input axis_id_e ax, input int cycles, output int steps);
        quad_t prev;
        quad_t cur;
        steps = 0;
        @(negedge osc);
        prev = quad_of(k2_port, ax);
        repeat (cycles) begin
            @(negedge osc);
            cur = quad_of(k2_port, ax);
            if (cur != prev) steps++;
            prev = cur;
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic test_reset_state();
        @(negedge osc);
        check_port(k2_port, port_val(1'b1, 8'h00), "K2 after reset, read active");
        check_port(k3_port, port_val(1'b0, 8'hFF), "K3 after reset");
        check_port(k4_port, port_val(1'b0, 8'hFF), "K4 after reset");
        @(posedge osc);
        k2_read <= 1'b0;
        @(negedge osc);
        check_port(k2_port, port_val(1'b0, 8'h00), "K2 after reset, no read");
        @(posedge osc);
        k2_read       <= 1'b1;
        mouse_enabled <= 1'b0;                      // Read cycle with the mouse off
        @(negedge osc);
        check_port(k2_port, port_val(1'b0, 8'h00), "K2 after reset, mouse disabled");
        @(posedge osc);
        mouse_enabled <= 1'b1;
        k2_read       <= 1'b0;
    endtask

    task automatic test_joystick();
        logic [15:0] j0;
        logic [15:0] j1;
        logic        s3;
        logic        s4;
        joy_port_e   sel;
        for (int i = 0; i < JOY_ITERS; i++) begin
            j0 = 16'($urandom());
            j1 = 16'($urandom());
            if (i % 2 == 1) begin
                j0[7:4] = 4'b0000;                  // Give fire a chance to read high
                j1[7:4] = 4'b0000;
            end
            s3 = 1'($urandom());
            s4 = 1'($urandom());
            case (i % 3)
                0:       sel = JOY_K3;
                1:       sel = JOY_K4;
                default: sel = JOY_NONE;
            endcase
            @(posedge osc);
            joy0      <= j0;
            joy1      <= j1;
            joy_port  <= sel;
            k3_select <= s3;
            k4_select <= s4;
            @(posedge osc);                         // Joystick byte register
            @(negedge osc);
            check_port(k3_port, port_val(s3, (sel == JOY_K3) ? joy_expected(j0, j1) : 8'hFF),
                       "K3 joystick");
            check_port(k4_port, port_val(s4, (sel == JOY_K4) ? joy_expected(j0, j1) : 8'hFF),
                       "K4 joystick");
        end
    endtask

    task automatic test_direction(input axis_id_e ax, input logic sign);
        logic [7:0] raw;
        quad_t      cur;
        quad_t      got;
        raw = sign ? ~8'hC0 : 8'hC0;                // Stored value is 0xC0 either way
        if (ax == AXIS_X) send_packet(raw, sign, 8'h00, 1'b0, 1'b0, 1'b0);
        else              send_packet(8'h00, 1'b0, raw, sign, 1'b0, 1'b0);
        repeat (6) @(posedge osc);                  // Let the old motion drain
        @(negedge osc);
        cur = quad_of(k2_port, ax);
        repeat (4) begin
            wait_quad_change(ax, cur, got);
            check_quad(got, next_in_sequence(cur, sign), "Direction step");
            cur = got;
        end
    endtask

    task automatic test_rate(input logic [7:0] mag, input int k, input logic moves);
        int steps;
        int exp;
        send_packet(mag, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0);
        repeat (10) @(posedge osc);
        count_steps(AXIS_X, WINDOW, steps);
        exp = moves ? WINDOW / (RATE_DIV * (2 ** (k + 1))) : 0;
        check_count(steps, exp, moves ? 1 : 0, $sformatf("Rate for magnitude %02h", mag));
    endtask

    task automatic test_idle_restart();
        int    steps;
        quad_t cur;
        quad_t got;
        logic [3:0] low;
        send_packet(8'hC0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0);
        count_steps(AXIS_X, IDLE_LIMIT + 100, steps);
        check_count(steps, IDLE_LIMIT / (RATE_DIV * 2), 2, "Steps before idle stop");
        count_steps(AXIS_X, 200, steps);
        check_count(steps, 0, 0, "Steps after idle stop");
        // Same motion again with a flipped toggle restarts the axis
        send_packet(8'hC0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0);
        @(negedge osc);
        cur = quad_of(k2_port, AXIS_X);
        wait_quad_change(AXIS_X, cur, got);
        // Zero motion with buttons, quad bits must hold still
        @(posedge osc);
        k2_read <= 1'b1;
        send_packet(8'h00, 1'b0, 8'h00, 1'b0, 1'b1, 1'b0);
        repeat (6) @(posedge osc);
        @(negedge osc);
        low = k2_port.data[3:0];
        repeat (20) @(negedge osc);
        check_port(k2_port, port_val(1'b1, {2'b10, 2'b00, low}), "K2 right button");
        send_packet(8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1);
        repeat (20) @(negedge osc);
        check_port(k2_port, port_val(1'b1, {2'b01, 2'b00, low}), "K2 left button");
    endtask

    // ------------------------------------------------------------------------
    // Watchdog and main sequence
    // ------------------------------------------------------------------------
    initial begin
        repeat (WATCHDOG_CYC) @(posedge osc);
        $display("Timeout: the tests did not complete within %0d cycles", WATCHDOG_CYC);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        void'($urandom(28));                        // Fixed seed for the run
        reset         = 1'b1;
        ps2_mouse     = '0;
        mouse_enabled = 1'b1;
        k2_read       = 1'b1;
        joy0          = 16'h0000;
        joy1          = 16'h0000;
        joy_port      = JOY_NONE;
        k3_select     = 1'b0;
        k4_select     = 1'b0;
        repeat (10) @(posedge osc);
        reset <= 1'b0;

        test_reset_state();
        test_joystick();
        test_direction(AXIS_X, 1'b0);
        test_direction(AXIS_X, 1'b1);
        test_direction(AXIS_Y, 1'b0);
        test_direction(AXIS_Y, 1'b1);
        test_rate(8'hC0, 0, 1'b1);
        test_rate(8'h30, 1, 1'b1);
        test_rate(8'h08, 2, 1'b1);
        test_rate(8'h01, 0, 1'b0);
        test_idle_restart();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== pmd_input_top.sv ====
`timescale 1ns/10ps

module pmd_input_top import pmd_input_pkg::*; #(
    parameter int unsigned RATE_DIV   = 35_446,    // About 260 Hz at 18.432 MHz
    parameter int unsigned IDLE_LIMIT = 4_608_000  // 0.25 s at 18.432 MHz
) (
    input  logic          osc,
    input  logic          reset,

    // Mouse side
    input  mouse_packet_t ps2_mouse,
    input  logic          mouse_enabled,
    input  logic          k2_read,

    // Joystick side
    input  logic [15:0]   joy0,
    input  logic [15:0]   joy1,
    input  joy_port_e     joy_port,
    input  logic          k3_select,
    input  logic          k4_select,

    output port_byte_t    k2_port,
    output port_byte_t    k3_port,
    output port_byte_t    k4_port
);

    axis_motion_t [NUM_AXES-1:0] motion;
    quad_t        [NUM_AXES-1:0] quad;
    logic [1:0]                  buttons;
    logic                        stopped;
    logic [PHASE_W-1:0]          rate_phase;

    // ------------------------------------------------------------------------
    // Mouse path, decoder feeds one stepper per axis
    // ------------------------------------------------------------------------
    mouse_packet_decoder #(
        .RATE_DIV   (RATE_DIV),
        .IDLE_LIMIT (IDLE_LIMIT)
    ) u_decoder (
        .osc        (osc),
        .reset      (reset),
        .ps2_mouse  (ps2_mouse),
        .motion     (motion),
        .buttons    (buttons),
        .stopped    (stopped),
        .rate_phase (rate_phase)
    );

    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        quadrature_axis u_axis (
            .osc        (osc),
            .reset      (reset),
            .motion     (motion[i]),
            .stopped    (stopped),
            .rate_phase (rate_phase),
            .quad       (quad[i])
        );
    end

    mouse_port_register u_k2 (
        .osc           (osc),
        .reset         (reset),
        .quad          (quad),
        .buttons       (buttons),
        .mouse_enabled (mouse_enabled),
        .k2_read       (k2_read),
        .k2_port       (k2_port)
    );

    // Joystick path, independent of the mouse
    joystick_mapper u_joy (
        .osc       (osc),
        .reset     (reset),
        .joy0      (joy0),
        .joy1      (joy1),
        .joy_port  (joy_port),
        .k3_select (k3_select),
        .k4_select (k4_select),
        .k3_port   (k3_port),
        .k4_port   (k4_port)
    );

endmodule

// ==== joystick_mapper.sv ====
`timescale 1ns/10ps

module joystick_mapper import pmd_input_pkg::*; (
    input  logic        osc,
    input  logic        reset,
    input  logic [15:0] joy0,
    input  logic [15:0] joy1,
    input  joy_port_e   joy_port,
    input  logic        k3_select,   // Former PC4 strobe
    input  logic        k4_select,   // Former PC0 strobe
    output port_byte_t  k3_port,
    output port_byte_t  k4_port
);

    logic [15:0] joy;          // Both controllers merged
    logic        fire;
    logic [7:0]  joy_byte;
    logic [7:0]  joy_byte_q;

    assign joy = joy0 | joy1;

    // Fire is high when no button is pressed, the port is active low
    assign fire = (joy[7:4] == 4'b0000);

    // ------------------------------------------------------------------------
    // Port byte, bit 7 down
    // 1, 1, 1, fire, ~left, ~right, ~up, ~down
    // ------------------------------------------------------------------------
    always_comb begin
        joy_byte[7:5] = 3'b111;
        joy_byte[4]   = fire;
        joy_byte[3]   = ~joy[1];
        joy_byte[2]   = ~joy[0];
        joy_byte[1]   = ~joy[3];
        joy_byte[0]   = ~joy[2];
    end

    always_ff @(posedge osc) begin
        if (reset) begin
            joy_byte_q <= 8'hFF;             // Idle port, nothing pressed
        end else begin
            joy_byte_q <= joy_byte;
        end
    end

    // ------------------------------------------------------------------------
    // Port routing, the unselected port reads as pulled up
    // ------------------------------------------------------------------------
    assign k3_port.drive = k3_select;
    assign k3_port.data  = (joy_port == JOY_K3) ? joy_byte_q : 8'hFF;

    assign k4_port.drive = k4_select;
    assign k4_port.data  = (joy_port == JOY_K4) ? joy_byte_q : 8'hFF;

endmodule

// ==== mouse_port_register.sv ====
`timescale 1ns/10ps

module mouse_port_register import pmd_input_pkg::*; (
    input  logic                   osc,
    input  logic                   reset,
    input  quad_t [NUM_AXES-1:0]   quad,
    input  logic [1:0]             buttons,        // {right, left}
    input  logic                   mouse_enabled,
    input  logic                   k2_read,        // CPU read cycle on K2
    output port_byte_t             k2_port
);

    logic [7:0] mouse_byte;   // Next K2 value
    logic [7:0] mouse_q;      // Registered K2 value

    // ------------------------------------------------------------------------
    // K2 byte layout, bit 7 down
    // right, left, 0, 0, X.b, X.a, Y.a, Y.b
    // ------------------------------------------------------------------------
    always_comb begin
        mouse_byte    = 8'h00;
        mouse_byte[7] = buttons[1];
        mouse_byte[6] = buttons[0];
        mouse_byte[3] = quad[AXIS_X].b;
        mouse_byte[2] = quad[AXIS_X].a;
        mouse_byte[1] = quad[AXIS_Y].a;   // Y pair swapped compared with X
        mouse_byte[0] = quad[AXIS_Y].b;
    end

    always_ff @(posedge osc) begin
        if (reset) begin
            mouse_q <= 8'h00;
        end else begin
            mouse_q <= mouse_byte;        // Refreshed every cycle
        end
    end

    // Drive only while the mouse is on and the CPU reads the port
    assign k2_port.drive = mouse_enabled & k2_read;
    assign k2_port.data  = mouse_q;

endmodule

// ==== quadrature_axis.sv ====
`timescale 1ns/10ps

module quadrature_axis import pmd_input_pkg::*; (
    input  logic               osc,
    input  logic               reset,
    input  axis_motion_t       motion,
    input  logic               stopped,
    input  logic [PHASE_W-1:0] rate_phase,
    output quad_t              quad
);

    logic sel_bit;   // Phase bit picked by magnitude, held low when too small to move
    logic sel_q;     // Last value of sel_bit, for edge detect
    logic step;

    // ------------------------------------------------------------------------
    // Rate select, larger motion uses a faster phase bit
    // ------------------------------------------------------------------------
    always_comb begin
        if (motion.mag[7:6] != 2'b00) begin
            sel_bit = rate_phase[0];       // Fastest
        end else if (motion.mag[5:4] != 2'b00) begin
            sel_bit = rate_phase[1];
        end else if (motion.mag[3]) begin
            sel_bit = rate_phase[2];
        end else if (motion.mag[2]) begin
            sel_bit = rate_phase[3];
        end else if (motion.mag[1]) begin
            sel_bit = rate_phase[4];       // Slowest
        end else begin
            sel_bit = 1'b0;                // Bit 0 alone is jitter, no step
        end
    end

    // Rising edge of the chosen bit, gated by the idle stop
    assign step = sel_bit & ~sel_q & ~stopped;

    always_ff @(posedge osc) begin
        if (reset) begin
            sel_q <= 1'b0;
        end else begin
            sel_q <= sel_bit;
        end
    end

    // ------------------------------------------------------------------------
    // Quadrature stepper
    // Sign 0 walks 00 10 11 01, sign 1 walks the reverse
    // ------------------------------------------------------------------------
    always_ff @(posedge osc) begin
        if (reset) begin
            quad <= '0;
        end else if (step) begin
            quad.a <= quad.b ^ ~motion.sign;
            quad.b <= quad.a ^ motion.sign;  // Old a, nonblocking
        end
    end

endmodule

// ==== mouse_packet_decoder.sv ====
`timescale 1ns/10ps

module mouse_packet_decoder import pmd_input_pkg::*; #(
    parameter int unsigned RATE_DIV   = 35_446,    // osc cycles per phase step
    parameter int unsigned IDLE_LIMIT = 4_608_000  // osc cycles to auto stop
) (
    input  logic                           osc,
    input  logic                           reset,
    input  mouse_packet_t                  ps2_mouse,
    output axis_motion_t [NUM_AXES-1:0]    motion,
    output logic [1:0]                     buttons,     // {right, left}
    output logic                           stopped,
    output logic [PHASE_W-1:0]             rate_phase
);

    localparam int DIV_W  = (RATE_DIV > 1) ? $clog2(RATE_DIV) : 1;
    localparam int IDLE_W = $clog2(IDLE_LIMIT + 1);

    mouse_packet_t   pkt_q;        // Sampled mouse word
    logic            toggle_last;  // Event bit of the last accepted packet
    logic            new_pkt;
    logic [DIV_W-1:0]  div_cnt;
    logic [IDLE_W-1:0] idle_cnt;

    // ------------------------------------------------------------------------
    // Input sample and packet detect
    // ------------------------------------------------------------------------
    always_ff @(posedge osc) begin
        pkt_q <= ps2_mouse;                          // Payload, free running
    end

    assign new_pkt = (pkt_q.event_tgl != toggle_last); // Any toggle change

    always_ff @(posedge osc) begin
        if (reset) begin
            toggle_last <= ps2_mouse.event_tgl;      // Reset itself is no packet
            motion      <= '0;
            buttons     <= 2'b00;
        end else begin
            buttons <= {pkt_q.right, pkt_q.left};
            if (new_pkt) begin
                toggle_last <= pkt_q.event_tgl;
                // Negative motion is kept as the one's complement
                motion[AXIS_X].sign <= pkt_q.x_sign;
                motion[AXIS_X].mag  <= pkt_q.x_sign ? ~pkt_q.x_mag : pkt_q.x_mag;
                motion[AXIS_Y].sign <= pkt_q.y_sign;
                motion[AXIS_Y].mag  <= pkt_q.y_sign ? ~pkt_q.y_mag : pkt_q.y_mag;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Idle timer, stops the axes when packets dry up
    // ------------------------------------------------------------------------
    always_ff @(posedge osc) begin
        if (reset) begin
            idle_cnt <= '0;
            stopped  <= 1'b1;                        // No motion until first packet
        end else if (new_pkt) begin
            idle_cnt <= '0;
            stopped  <= 1'b0;
        end else if (!stopped) begin
            if (idle_cnt == IDLE_W'(IDLE_LIMIT - 1)) begin
                stopped <= 1'b1;                     // Hold here until next packet
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    // Step-rate divider, each phase bit is half the rate of the one below
    always_ff @(posedge osc) begin
        if (reset) begin
            div_cnt    <= '0;
            rate_phase <= '0;
        end else if (div_cnt == DIV_W'(RATE_DIV - 1)) begin
            div_cnt    <= '0;
            rate_phase <= rate_phase + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

// ==== pmd_input_pkg.sv ====
package pmd_input_pkg;

    // ------------------------------------------------------------------------
    // Widths and counts
    // ------------------------------------------------------------------------
    localparam int MAG_W    = 8;    // Motion magnitude from the PS/2 packet
    localparam int PHASE_W  = 6;    // Step-rate phase counter
    localparam int NUM_AXES = 2;    // X and Y

    // Axis index into the motion and quadrature arrays
    typedef enum logic [0:0] {
        AXIS_X = 1'b0,
        AXIS_Y = 1'b1
    } axis_id_e;

    // Joystick routing, code 2'b11 is treated as no port
    typedef enum logic [1:0] {
        JOY_NONE = 2'b00,
        JOY_K3   = 2'b01,
        JOY_K4   = 2'b10
    } joy_port_e;

    // ------------------------------------------------------------------------
    // PS/2 mouse word as delivered by the host framework, 25 bits
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic             event_tgl;  // Flips once per received packet
        logic [MAG_W-1:0] y_mag;      // Raw Y movement byte
        logic [MAG_W-1:0] x_mag;      // Raw X movement byte
        logic [1:0]       ovf;        // Overflow flags, ignored
        logic             y_sign;     // 1 = down
        logic             x_sign;     // 1 = left
        logic [1:0]       misc;       // Always-one and middle button, ignored
        logic             right;      // Right button
        logic             left;       // Left button
    } mouse_packet_t;

    // Stored per-axis motion, magnitude already one's-complemented for sign 1
    typedef struct packed {
        logic             sign;
        logic [MAG_W-1:0] mag;
    } axis_motion_t;

    // One quadrature pair as seen on K2
    typedef struct packed {
        logic a;
        logic b;
    } quad_t;

    // Port byte with its output enable, replaces the old tri-state buses
    typedef struct packed {
        logic       drive;
        logic [7:0] data;
    } port_byte_t;

endpackage
